// ==== src/video_macros.svh ====
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

// horizontal geometry in pixel clocks
`define H_VISIBLE       32              // visible pixels per line
`define H_FRONT         4               // front porch
`define H_SYNC          4               // hsync pulse width
`define H_BACK          8               // back porch
`define H_TOTAL         (`H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK)

// vertical geometry in lines
// reduced mode so a frame is only a few hundred clocks
`define V_VISIBLE       8               // visible lines per frame
`define V_FRONT         1               // front porch
`define V_SYNC          1               // vsync pulse width
`define V_BACK          2               // back porch
`define V_TOTAL         (`V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK)

// beam state to colour output latency
`define PIXEL_PIPE      3

// config defaults
`define BORDER_RESET    8'h08           // dark grey border

`endif

// ==== src/video_timing_pkg.sv ====
`default_nettype none

`include "video_macros.svh"

package video_timing_pkg;

    typedef logic [$clog2(`H_TOTAL)-1:0] hres_t;   // pixel counter
    typedef logic [$clog2(`V_TOTAL)-1:0] vres_t;   // line counter

    // raw beam position, not delayed
    typedef struct packed {
        hres_t  h_count;
        vres_t  v_count;
        logic   h_visible;                      // inside visible pixels
        logic   v_visible;                      // inside visible lines
        logic   end_of_line;                    // last clock of any line
        logic   end_of_frame;                   // last clock of the frame
        logic   end_of_visible;                 // last clock of last visible line
    } beam_t;

    // pin level sync, already aligned with colour output
    typedef struct packed {
        logic   hsync;
        logic   vsync;
        logic   h_blank;
        logic   v_blank;
        logic   dv_de;
    } sync_t;

endpackage

`default_nettype wire

// ==== src/xr_regs_pkg.sv ====
`default_nettype none

package xr_regs_pkg;

    typedef logic [15:0] word_t;                // register and vram data
    typedef logic [15:0] addr_t;                // vram word address
    typedef logic [7:0]  color_t;               // colour index

    // config register numbers
    typedef enum logic [5:0] {
        XR_VID_CTRL     = 6'h00,                // border colour
        XR_SCANLINE     = 6'h02,                // read only
        XR_VID_LEFT     = 6'h03,
        XR_VID_RIGHT    = 6'h04,
        XR_PA_GFX_CTRL  = 6'h10,                // colour base, blank
        XR_PA_DISP_ADDR = 6'h12,
        XR_PA_LINE_LEN  = 6'h13
    } xr_reg_e;

    // display window settings
    typedef struct packed {
        color_t                     border_color;
        video_timing_pkg::hres_t    vid_left;   // first window pixel
        video_timing_pkg::hres_t    vid_right;  // one past last window pixel
    } vid_cfg_t;

    // bitmap playfield settings
    typedef struct packed {
        color_t colorbase;                      // xor applied to fetched index
        logic   blank;                          // playfield off, border shown
        addr_t  start_addr;                     // word address of first line
        word_t  line_len;                       // words between lines
    } pf_cfg_t;

endpackage

`default_nettype wire

// ==== src/video_timing.sv ====
`default_nettype none

`include "video_macros.svh"

module video_timing (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    output      video_timing_pkg::beam_t    beam_o,
    output      video_timing_pkg::sync_t    sync_o,
    output      logic                       video_intr_o
);
    import video_timing_pkg::*;

    localparam hres_t HSYNC_START = hres_t'(`H_VISIBLE + `H_FRONT);
    localparam hres_t HSYNC_END   = hres_t'(`H_VISIBLE + `H_FRONT + `H_SYNC);
    localparam vres_t VSYNC_START = vres_t'(`V_VISIBLE + `V_FRONT);
    localparam vres_t VSYNC_END   = vres_t'(`V_VISIBLE + `V_FRONT + `V_SYNC);

    // pipe state while in reset, blanked with syncs off
    localparam sync_t SYNC_IDLE = '{
        hsync:   1'b0,
        vsync:   1'b0,
        h_blank: 1'b1,
        v_blank: 1'b1,
        dv_de:   1'b0
    };

    hres_t                      h_count;
    vres_t                      v_count;
    sync_t                      sync_next;
    sync_t [`PIXEL_PIPE-1:0]    sync_pipe;
    logic  [`PIXEL_PIPE-1:0]    eov_pipe;

    // beam counters
    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_count <= '0;
            v_count <= '0;
        end else if (beam_o.end_of_line) begin
            h_count <= '0;
            v_count <= beam_o.end_of_frame ? '0 : v_count + 1'b1;
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    always_comb begin
        beam_o.h_count        = h_count;
        beam_o.v_count        = v_count;
        beam_o.h_visible      = h_count < hres_t'(`H_VISIBLE);
        beam_o.v_visible      = v_count < vres_t'(`V_VISIBLE);
        beam_o.end_of_line    = h_count == hres_t'(`H_TOTAL - 1);
        beam_o.end_of_frame   = beam_o.end_of_line && (v_count == vres_t'(`V_TOTAL - 1));
        beam_o.end_of_visible = beam_o.end_of_line && (v_count == vres_t'(`V_VISIBLE - 1));
    end

    always_comb begin
        sync_next.hsync   = (h_count >= HSYNC_START) && (h_count < HSYNC_END);
        sync_next.vsync   = (v_count >= VSYNC_START) && (v_count < VSYNC_END);
        sync_next.h_blank = !beam_o.h_visible;
        sync_next.v_blank = !beam_o.v_visible;
        sync_next.dv_de   = beam_o.h_visible && beam_o.v_visible;
    end

    // delay line so syncs match pixel pipeline
    always_ff @(posedge clk) begin
        if (reset_i) begin
            sync_pipe    <= {`PIXEL_PIPE{SYNC_IDLE}};
            eov_pipe     <= '0;
            video_intr_o <= 1'b0;
        end else begin
            sync_pipe    <= {sync_pipe[`PIXEL_PIPE-2:0], sync_next};
            eov_pipe     <= {eov_pipe[`PIXEL_PIPE-2:0], beam_o.end_of_visible};
            video_intr_o <= eov_pipe[`PIXEL_PIPE-1];   // lands on first v_blank clock
        end
    end

    assign sync_o = sync_pipe[`PIXEL_PIPE-1];

    hsync_width: assert property (
        @(posedge clk) disable iff (reset_i)
        $rose(sync_o.hsync) |-> sync_o.hsync [*`H_SYNC] ##1 !sync_o.hsync
    ) else $error("hsync pulse width is not H_SYNC");

endmodule

`default_nettype wire

// ==== src/video_config.sv ====
`default_nettype none

`include "video_macros.svh"

module video_config (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       reg_wr_i,
    input  wire xr_regs_pkg::xr_reg_e       reg_num_i,
    input  wire xr_regs_pkg::word_t         reg_data_i,
    input  wire video_timing_pkg::vres_t    v_count_i,
    output      xr_regs_pkg::word_t         reg_data_o,
    output      xr_regs_pkg::vid_cfg_t      vid_cfg_o,
    output      xr_regs_pkg::pf_cfg_t       pf_cfg_o
);
    import xr_regs_pkg::*;

    localparam int HRES_W = $bits(vid_cfg_o.vid_left);

    word_t rd_word;

    // register writes
    always_ff @(posedge clk) begin
        if (reset_i) begin
            vid_cfg_o.border_color <= `BORDER_RESET;
            vid_cfg_o.vid_left     <= '0;
            vid_cfg_o.vid_right    <= HRES_W'(`H_VISIBLE);  // full width window
            pf_cfg_o.colorbase     <= '0;
            pf_cfg_o.blank         <= 1'b1;                 // playfield starts off
            pf_cfg_o.start_addr    <= '0;
            pf_cfg_o.line_len      <= word_t'(`H_VISIBLE / 2);
        end else if (reg_wr_i) begin
            case (reg_num_i)
                XR_VID_CTRL: begin
                    vid_cfg_o.border_color <= reg_data_i[7:0];
                end
                XR_VID_LEFT: begin
                    vid_cfg_o.vid_left <= reg_data_i[HRES_W-1:0];
                end
                XR_VID_RIGHT: begin
                    vid_cfg_o.vid_right <= reg_data_i[HRES_W-1:0];
                end
                XR_PA_GFX_CTRL: begin
                    pf_cfg_o.colorbase <= reg_data_i[15:8];
                    pf_cfg_o.blank     <= reg_data_i[7];
                end
                XR_PA_DISP_ADDR: begin
                    pf_cfg_o.start_addr <= reg_data_i;
                end
                XR_PA_LINE_LEN: begin
                    pf_cfg_o.line_len <= reg_data_i;
                end
                default: begin
                end
            endcase
        end
    end

    // read mux, unused numbers give zero
    always_comb begin
        rd_word = '0;
        case (reg_num_i)
            XR_VID_CTRL:     rd_word = word_t'(vid_cfg_o.border_color);
            XR_SCANLINE:     rd_word = word_t'(v_count_i);    // live beam line
            XR_VID_LEFT:     rd_word = word_t'(vid_cfg_o.vid_left);
            XR_VID_RIGHT:    rd_word = word_t'(vid_cfg_o.vid_right);
            XR_PA_GFX_CTRL:  rd_word = {pf_cfg_o.colorbase, pf_cfg_o.blank, 7'b0};
            XR_PA_DISP_ADDR: rd_word = pf_cfg_o.start_addr;
            XR_PA_LINE_LEN:  rd_word = pf_cfg_o.line_len;
            default:         rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        reg_data_o <= rd_word;
    end

    wr_num_known: assert property (
        @(posedge clk) disable iff (reset_i)
        reg_wr_i |-> !$isunknown(reg_num_i)
    ) else $error("register write with unknown register number");

endmodule

`default_nettype wire

// ==== src/bitmap_playfield.sv ====
`default_nettype none

`include "video_macros.svh"

module bitmap_playfield (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire video_timing_pkg::beam_t    beam_i,
    input  wire xr_regs_pkg::vid_cfg_t      vid_cfg_i,
    input  wire xr_regs_pkg::pf_cfg_t       pf_cfg_i,
    output      logic                       vram_sel_o,
    output      xr_regs_pkg::addr_t         vram_addr_o,
    input  wire xr_regs_pkg::word_t         vram_data_i,
    output      xr_regs_pkg::color_t        color_index_o
);
    import video_timing_pkg::*;
    import xr_regs_pkg::*;

    // what each pixel slot in the pipe will show
    typedef enum logic [1:0] {
        PIX_BLANK,
        PIX_BORDER,
        PIX_BITMAP
    } pix_kind_e;

    addr_t      line_addr;                      // word address of current line
    logic       visible;
    logic       in_window;
    hres_t      offset;                         // pixel offset inside window
    pix_kind_e  kind_next;
    pix_kind_e  s1_kind;                        // address on vram port
    pix_kind_e  s2_kind;                        // data on vram port
    logic       s1_odd;
    logic       s2_odd;

    always_comb begin
        visible   = beam_i.h_visible && beam_i.v_visible;
        in_window = (beam_i.h_count >= vid_cfg_i.vid_left) &&
                    (beam_i.h_count < vid_cfg_i.vid_right);
        offset    = beam_i.h_count - vid_cfg_i.vid_left;
        if (!visible) begin
            kind_next = PIX_BLANK;
        end else if (in_window && !pf_cfg_i.blank) begin
            kind_next = PIX_BITMAP;
        end else begin
            kind_next = PIX_BORDER;
        end
    end

    // line start tracking
    always_ff @(posedge clk) begin
        if (reset_i) begin
            line_addr <= '0;
        end else if (beam_i.end_of_frame) begin
            line_addr <= pf_cfg_i.start_addr;
        end else if (beam_i.end_of_line && beam_i.v_visible) begin
            line_addr <= line_addr + pf_cfg_i.line_len;    // wraps at 16 bits
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vram_sel_o    <= 1'b0;
            s1_kind       <= PIX_BLANK;
            s2_kind       <= PIX_BLANK;
            color_index_o <= '0;
        end else begin
            vram_sel_o <= kind_next == PIX_BITMAP;
            s1_kind    <= kind_next;
            s2_kind    <= s1_kind;
            case (s2_kind)
                PIX_BITMAP: begin
                    // high byte is the left pixel
                    color_index_o <= (s2_odd ? vram_data_i[7:0] : vram_data_i[15:8]) ^
                                     pf_cfg_i.colorbase;
                end
                PIX_BORDER: begin
                    color_index_o <= vid_cfg_i.border_color;
                end
                default: begin
                    color_index_o <= '0;
                end
            endcase
        end
    end

    // fetch address and byte select
    always_ff @(posedge clk) begin
        vram_addr_o <= line_addr + addr_t'(offset >> 1);
        s1_odd      <= offset[0];
        s2_odd      <= s1_odd;
    end

    fetch_in_frame: assert property (
        @(posedge clk) disable iff (reset_i)
        (beam_i.h_count >= hres_t'(`H_VISIBLE) || beam_i.v_count >= vres_t'(`V_VISIBLE))
            |=> !vram_sel_o
    ) else $error("vram read outside the visible frame");

endmodule

`default_nettype wire

// ==== src/video_gen.sv ====
`default_nettype none

module video_gen (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    // config register port
    input  wire logic                   reg_wr_i,
    input  wire xr_regs_pkg::xr_reg_e   reg_num_i,
    input  wire xr_regs_pkg::word_t     reg_data_i,
    output      xr_regs_pkg::word_t     reg_data_o,
    output      logic                   video_intr_o,  // once per frame at vblank
    // vram read port
    output      logic                   vram_sel_o,
    output      xr_regs_pkg::addr_t     vram_addr_o,
    input  wire xr_regs_pkg::word_t     vram_data_i,
    // video out
    output      logic                   hsync_o,
    output      logic                   vsync_o,
    output      logic                   h_blank_o,
    output      logic                   v_blank_o,
    output      logic                   dv_de_o,
    output      xr_regs_pkg::color_t    color_index_o
);
    import video_timing_pkg::*;
    import xr_regs_pkg::*;

    beam_t      beam;
    sync_t      sync;
    vid_cfg_t   vid_cfg;
    pf_cfg_t    pf_cfg;

    video_timing u_timing (
        .clk          (clk),
        .reset_i      (reset_i),
        .beam_o       (beam),
        .sync_o       (sync),
        .video_intr_o (video_intr_o)
    );

    video_config u_config (
        .clk        (clk),
        .reset_i    (reset_i),
        .reg_wr_i   (reg_wr_i),
        .reg_num_i  (reg_num_i),
        .reg_data_i (reg_data_i),
        .v_count_i  (beam.v_count),
        .reg_data_o (reg_data_o),
        .vid_cfg_o  (vid_cfg),
        .pf_cfg_o   (pf_cfg)
    );

    bitmap_playfield u_playfield (
        .clk           (clk),
        .reset_i       (reset_i),
        .beam_i        (beam),
        .vid_cfg_i     (vid_cfg),
        .pf_cfg_i      (pf_cfg),
        .vram_sel_o    (vram_sel_o),
        .vram_addr_o   (vram_addr_o),
        .vram_data_i   (vram_data_i),
        .color_index_o (color_index_o)
    );

    // sync bundle onto pins
    assign hsync_o   = sync.hsync;
    assign vsync_o   = sync.vsync;
    assign h_blank_o = sync.h_blank;
    assign v_blank_o = sync.v_blank;
    assign dv_de_o   = sync.dv_de;

endmodule

`default_nettype wire

// ==== verification/video_gen_tb.sv ====
`default_nettype none

`include "video_macros.svh"

module video_gen_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import video_timing_pkg::*;
    import xr_regs_pkg::*;

    localparam word_t SCRAMBLE       = 16'hA5C3;     // vram content is address xor this
    localparam int    RESET_CYCLES   = 10;
    localparam int    PIXEL_FRAMES   = 5;
    localparam int    TIMEOUT_CYCLES = 8 * `H_TOTAL * `V_TOTAL + RESET_CYCLES;

    logic       clk = 1'b0;
    logic       reset_i;
    logic       reg_wr_i;
    xr_reg_e    reg_num_i;
    word_t      reg_data_i;
    word_t      reg_data_o;
    logic       video_intr_o;
    logic       vram_sel_o;
    addr_t      vram_addr_o;
    word_t      vram_data_i = '0;
    logic       hsync_o;
    logic       vsync_o;
    logic       h_blank_o;
    logic       v_blank_o;
    logic       dv_de_o;
    color_t     color_index_o;

    // register copies starting at reset defaults
    color_t     m_border    = `BORDER_RESET;
    hres_t      m_left      = '0;
    hres_t      m_right     = hres_t'(`H_VISIBLE);
    color_t     m_colorbase = '0;
    logic       m_blank     = 1'b1;
    addr_t      m_start     = '0;
    word_t      m_len       = word_t'(`H_VISIBLE / 2);

    // beam position as seen at the pins
    hres_t      x_pos        = '0;
    int         y_pos        = 0;
    int         vb_line      = `V_TOTAL;        // line number inside vertical blank
    int         hvis_len     = 0;
    int         hsync_len    = 0;
    logic       prev_h_blank = 1'b1;
    logic       prev_v_blank = 1'b1;
    logic       prev_hsync   = 1'b0;

    logic       rd_pending = 1'b0;              // vram read issued last cycle
    addr_t      rd_addr    = '0;
    int         seed;
    int         cycles     = 0;

    video_gen uut (
        .clk           (clk),
        .reset_i       (reset_i),
        .reg_wr_i      (reg_wr_i),
        .reg_num_i     (reg_num_i),
        .reg_data_i    (reg_data_i),
        .reg_data_o    (reg_data_o),
        .video_intr_o  (video_intr_o),
        .vram_sel_o    (vram_sel_o),
        .vram_addr_o   (vram_addr_o),
        .vram_data_i   (vram_data_i),
        .hsync_o       (hsync_o),
        .vsync_o       (vsync_o),
        .h_blank_o     (h_blank_o),
        .v_blank_o     (v_blank_o),
        .dv_de_o       (dv_de_o),
        .color_index_o (color_index_o)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Regression failed");
            $fatal(1, "simulation timed out after %0d clock cycles", cycles);
        end
    end

    // vram with one cycle read latency
    always @(negedge clk) begin
        vram_data_i <= rd_pending ? (rd_addr ^ SCRAMBLE) : '0;
        rd_pending  <= vram_sel_o;
        rd_addr     <= vram_addr_o;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, actual,
                     expected);
            $display("Regression failed");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    function automatic color_t expected_color(input hres_t x, input int y);
        hres_t  off;
        addr_t  addr;
        word_t  data;
        if (m_blank || x < m_left || x >= m_right) begin
            return m_border;
        end
        off  = x - m_left;
        addr = m_start + addr_t'(y) * m_len + addr_t'(off >> 1);
        data = addr ^ SCRAMBLE;
        return (off[0] ? data[7:0] : data[15:8]) ^ m_colorbase;   // left pixel in high byte
    endfunction

    function automatic logic known_register(input logic [5:0] num);
        case (num)
            6'h00, 6'h02, 6'h03, 6'h04, 6'h10, 6'h12, 6'h13: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // pin monitor sampling at the falling edge where outputs are stable
    always @(negedge clk) begin
        check_value("dv_de_o", 32'(dv_de_o), 32'(!h_blank_o && !v_blank_o));
        check_value("video_intr_o", 32'(video_intr_o), 32'(v_blank_o && !prev_v_blank));
        if (h_blank_o || v_blank_o) begin
            check_value("color_index_o", 32'(color_index_o), 32'h0);
        end else begin
            check_value("color_index_o", 32'(color_index_o), 32'(expected_color(x_pos, y_pos)));
        end
        if (!h_blank_o) begin
            hvis_len++;
        end else if (!prev_h_blank) begin
            check_value("h_blank_o low cycles", hvis_len, `H_VISIBLE);
            hvis_len = 0;
        end
        if (hsync_o) begin
            hsync_len++;
        end else if (prev_hsync) begin
            check_value("hsync_o high cycles", hsync_len, `H_SYNC);
            hsync_len = 0;
        end
        if (v_blank_o && !prev_v_blank) begin
            check_value("visible lines per frame", y_pos, `V_VISIBLE);
            vb_line = 0;
        end else if (!h_blank_o && prev_h_blank) begin
            vb_line++;                              // next line starts
        end
        check_value("vsync_o", 32'(vsync_o),
                    32'(v_blank_o && vb_line >= `V_FRONT && vb_line < `V_FRONT + `V_SYNC));
        x_pos = h_blank_o ? '0 : x_pos + 1'b1;
        if (v_blank_o) begin
            y_pos = 0;
        end else if (h_blank_o && !prev_h_blank) begin
            y_pos++;                                // line done
        end
        prev_h_blank = h_blank_o;
        prev_v_blank = v_blank_o;
        prev_hsync   = hsync_o;
    end

    task automatic write_reg(input xr_reg_e num, input word_t data);
        @(negedge clk);
        reg_wr_i   = 1'b1;
        reg_num_i  = num;
        reg_data_i = data;
        @(negedge clk);
        reg_wr_i = 1'b0;
    endtask

    // read data arrives one cycle after the number
    task automatic read_reg(input xr_reg_e num, output word_t value);
        @(negedge clk);
        reg_num_i = num;
        @(negedge clk);
        value = reg_data_o;
    endtask

    task automatic wait_vblank_start();
        while (v_blank_o) @(negedge clk);
        while (!v_blank_o) @(negedge clk);
    endtask

    task automatic check_idle_outputs();
        check_value("hsync_o", 32'(hsync_o), 32'h0);
        check_value("vsync_o", 32'(vsync_o), 32'h0);
        check_value("dv_de_o", 32'(dv_de_o), 32'h0);
        check_value("video_intr_o", 32'(video_intr_o), 32'h0);
        check_value("vram_sel_o", 32'(vram_sel_o), 32'h0);
        check_value("color_index_o", 32'(color_index_o), 32'h0);
    endtask

    task automatic readback_registers();
        word_t rd;
        read_reg(XR_VID_CTRL, rd);
        check_value("VID_CTRL", 32'(rd), 32'(m_border));
        read_reg(XR_VID_LEFT, rd);
        check_value("VID_LEFT", 32'(rd), 32'(m_left));
        read_reg(XR_VID_RIGHT, rd);
        check_value("VID_RIGHT", 32'(rd), 32'(m_right));
        read_reg(XR_PA_GFX_CTRL, rd);
        check_value("PA_GFX_CTRL", 32'(rd), 32'({m_colorbase, m_blank, 7'b0}));
        read_reg(XR_PA_DISP_ADDR, rd);
        check_value("PA_DISP_ADDR", 32'(rd), 32'(m_start));
        read_reg(XR_PA_LINE_LEN, rd);
        check_value("PA_LINE_LEN", 32'(rd), 32'(m_len));
    endtask

    // new random frame setup while the pins are in vertical blank
    task automatic configure_frame();
        logic [31:0] r;
        logic [5:0]  junk_num;
        word_t       data;
        word_t       rd;
        r    = $random(seed);
        data = r[15:0];
        write_reg(XR_VID_CTRL, data);
        m_border = data[7:0];
        r    = $random(seed);
        data = {r[15:6], 2'b00, r[3:0]};            // left edge 0..15
        write_reg(XR_VID_LEFT, data);
        m_left = hres_t'(data);
        r    = $random(seed);
        data = {r[15:6], 6'(16 + r[4:0])};         // right edge 16..47
        write_reg(XR_VID_RIGHT, data);
        m_right = hres_t'(data);
        r    = $random(seed);
        data = {r[15:8], 1'b0, r[6:0]};            // playfield on
        write_reg(XR_PA_GFX_CTRL, data);
        m_colorbase = data[15:8];
        m_blank     = data[7];
        r = $random(seed);
        write_reg(XR_PA_DISP_ADDR, r[15:0]);
        m_start = r[15:0];
        write_reg(XR_PA_LINE_LEN, r[31:16]);
        m_len = r[31:16];
        r        = $random(seed);
        junk_num = known_register(r[5:0]) ? 6'h3F : r[5:0];
        write_reg(xr_reg_e'(junk_num), r[31:16]);
        read_reg(xr_reg_e'(junk_num), rd);
        check_value("unused register", 32'(rd), 32'h0);
        readback_registers();
        read_reg(XR_SCANLINE, rd);
        check_value("SCANLINE in vertical blank", 32'(rd >= `V_VISIBLE && rd < `V_TOTAL), 32'h1);
    endtask

    initial begin
        seed       = 72781;
        reset_i    = 1'b1;
        reg_wr_i   = 1'b0;
        reg_num_i  = XR_VID_CTRL;
        reg_data_i = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        check_idle_outputs();
        reset_i = 1'b0;
        readback_registers();                       // reset defaults
        repeat (PIXEL_FRAMES) begin
            wait_vblank_start();
            configure_frame();
        end
        wait_vblank_start();                        // last random frame fully drawn
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== video_gen.f ====
+incdir+src
src/video_timing_pkg.sv
src/xr_regs_pkg.sv
src/video_timing.sv
src/video_config.sv
src/bitmap_playfield.sv
src/video_gen.sv
verification/video_gen_tb.sv

// ==== Makefile ====
SOURCES := video_gen.f $(wildcard src/*.sv src/*.svh verification/*.sv)

.PHONY: run clean

run: obj_dir/Vvideo_gen_tb
	obj_dir/Vvideo_gen_tb

obj_dir/Vvideo_gen_tb: $(SOURCES)
	verilator --binary --assert -j 0 --top-module video_gen_tb -f video_gen.f -o Vvideo_gen_tb

clean:
	rm -rf obj_dir
